// ==== source/joy_pkg.sv ====
/*
  Joystick chain layout for the serial DB9 adapter board.
  Every joystick bit is active low, so a released control reads 1.
  Slot map entries pack a destination player in [5:4] and a bit index in [3:0].
*/
package joy_pkg;

  // Frame timing ------------------------------
  localparam int joy_frame_slots = 26;
  localparam int joy_slot_cycles = 2;
  localparam int joy_slot_w      = 5;
  localparam int joy_phase_w     = $clog2(joy_slot_cycles);

  localparam logic [1:0] joy_dst_none = 2'd0;  // Slot carries nothing
  localparam logic [1:0] joy_dst_p1   = 2'd1;
  localparam logic [1:0] joy_dst_p2   = 2'd2;

  // One controller word, seen as raw slot target or as named controls
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      logic       reset_n;   // Bit 11
      logic       button_c;
      logic       button_b;
      logic       mode;
      logic       start;
      logic       coin;
      logic [1:0] fire;
      logic       up;
      logic       down;
      logic       left;
      logic       right;     // Bit 0
    } fields;
  } joy_word_u;

  // Slot to destination map ------------------------------
  localparam logic [5:0] joy_slot_map [joy_frame_slots] = '{
    {joy_dst_none, 4'd0}, {joy_dst_none, 4'd0},                       // Load, dummy
    {joy_dst_p1, 4'd8}, {joy_dst_p1, 4'd6}, {joy_dst_p1, 4'd5}, {joy_dst_p1, 4'd4},
    {joy_dst_p1, 4'd3}, {joy_dst_p1, 4'd2}, {joy_dst_p1, 4'd1}, {joy_dst_p1, 4'd0},
    {joy_dst_p2, 4'd8}, {joy_dst_p2, 4'd6}, {joy_dst_p2, 4'd5}, {joy_dst_p2, 4'd4},
    {joy_dst_p2, 4'd3}, {joy_dst_p2, 4'd2}, {joy_dst_p2, 4'd1}, {joy_dst_p2, 4'd0},
    {joy_dst_p2, 4'd10}, {joy_dst_p2, 4'd11}, {joy_dst_p2, 4'd9}, {joy_dst_p2, 4'd7},
    {joy_dst_p1, 4'd10}, {joy_dst_p1, 4'd11}, {joy_dst_p1, 4'd9}, {joy_dst_p1, 4'd7}
  };

endpackage

// ==== source/kbd_pkg.sv ====
/*
  PS/2 set 2 scan codes used by the front end, plus receive timing.
  Only the five keys below are decoded. Everything else is ignored.
*/
package kbd_pkg;

  // Prefixes ------------------------------
  localparam logic [7:0] code_break = 8'hF0;  // Key release follows
  localparam logic [7:0] code_ext   = 8'hE0;  // Extended key follows

  // Keys of interest ------------------------------
  localparam logic [7:0] code_ctrl   = 8'h14;
  localparam logic [7:0] code_alt    = 8'h11;
  localparam logic [7:0] code_del    = 8'h71;  // Counts only after E0
  localparam logic [7:0] code_bksp   = 8'h66;
  localparam logic [7:0] code_scroll = 8'h7E;

  // Receiver idle limit in ena_x cycles
  localparam int ps2_timeout = 2000;
  localparam int ps2_idle_w  = $clog2(ps2_timeout);

endpackage

// ==== source/joy_serial_reader.sv ====
/*
  Serial reader for a 74165 style joystick chain.
  The chain loads while joy_load is low and shifts on the rising joy_clk edge.
  joy1 and joy2 change together once per frame of 52 cycles.
*/
module joy_serial_reader (
  input  logic               ena_x,
  input  logic               pll_lckd,
  input  logic               joy_data,
  output logic               joy_clk,
  output logic               joy_load,
  output joy_pkg::joy_word_u joy1,
  output joy_pkg::joy_word_u joy2
);

  logic                            run;        // Low only in the first cycle out of reset
  logic [joy_pkg::joy_phase_w-1:0] phase;
  logic [joy_pkg::joy_slot_w-1:0]  slot;
  logic                            slot_end;
  logic                            frame_end;
  logic                            frame_start;
  logic [5:0]                      map_entry;
  joy_pkg::joy_word_u              shadow1;
  joy_pkg::joy_word_u              shadow2;

  assign slot_end    = (phase == joy_pkg::joy_slot_cycles - 1);
  assign frame_end   = slot_end && (slot == joy_pkg::joy_frame_slots - 1);
  assign frame_start = (slot == '0) && (phase == '0);

  // Slot sequencing ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      run   <= 1'b0;
      phase <= '0;
      slot  <= '0;
    end else begin
      run <= 1'b1;
      if (run) begin
        if (slot_end) begin
          phase <= '0;
          slot  <= frame_end ? '0 : slot + 1'b1;
        end else begin
          phase <= phase + 1'b1;
        end
      end
    end
  end

  // Pin drive
  assign joy_load = !(run && (slot == '0));   // Parallel load in slot 0
  assign joy_clk  = run && (phase != '0);     // High in second half of slot

  assign map_entry = joy_pkg::joy_slot_map[slot];

  // Capture and publish ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      shadow1.raw <= '1;
      shadow2.raw <= '1;
      joy1.raw    <= '1;
      joy2.raw    <= '1;
    end else if (run) begin
      if (slot_end) begin
        // Sample just before the next rising joy_clk
        if (map_entry[5:4] == joy_pkg::joy_dst_p1) begin
          shadow1.raw[map_entry[3:0]] <= joy_data;
        end
        if (map_entry[5:4] == joy_pkg::joy_dst_p2) begin
          shadow2.raw[map_entry[3:0]] <= joy_data;
        end
      end
      if (frame_start) begin
        joy1 <= shadow1;   // Whole frame at once
        joy2 <= shadow2;
      end
    end
  end

endmodule

// ==== source/ps2_receiver.sv ====
/*
  PS/2 device-to-host frame receiver. Reception only.
  ps2_clk must stay low or high for more than two ena_x cycles.
  A partial frame is dropped after kbd_pkg::ps2_timeout idle cycles.
*/
module ps2_receiver (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] scan_code,
  output logic       code_strobe,
  output logic       frame_err
);

  logic [1:0]                     clk_sync;
  logic [1:0]                     data_sync;
  logic                           clk_prev;
  logic                           clk_fall;
  logic [3:0]                     bit_cnt;
  logic [9:0]                     shift;      // Bits received so far, LSB first
  logic [10:0]                    frame;
  logic                           frame_ok;
  logic                           last_bit;
  logic [kbd_pkg::ps2_idle_w-1:0] idle_cnt;
  logic                           idle_out;

  // Synchronizers ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= 2'b11;   // Bus idles high
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev && !clk_sync[1];
  assign last_bit = (bit_cnt == 4'd10);

  // Frame as it stands with the bit arriving now
  assign frame    = {data_sync[1], shift};
  assign frame_ok = !frame[0] && (^frame[9:1]) && frame[10];  // Start, odd parity, stop

  assign idle_out = (idle_cnt == kbd_pkg::ps2_timeout - 1);

  // Bit counter and status ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt     <= '0;
      idle_cnt    <= '0;
      code_strobe <= 1'b0;
      frame_err   <= 1'b0;
    end else begin
      code_strobe <= 1'b0;
      frame_err   <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        if (last_bit) begin
          bit_cnt     <= '0;
          code_strobe <= frame_ok;
          frame_err   <= !frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        if (!idle_out) begin
          idle_cnt <= idle_cnt + 1'b1;
        end else begin
          bit_cnt <= '0;   // Stale partial frame
        end
      end
    end
  end

  // Data path
  always_ff @(posedge ena_x) begin
    if (clk_fall) begin
      shift <= frame[10:1];
      if (last_bit) begin
        scan_code <= frame[8:1];
      end
    end
  end

endmodule

// ==== source/key_decoder.sv ====
/*
  Decodes the few key combinations the board reacts to.
  Ctrl and Alt count from either side of the keyboard.
  Del counts only with the E0 prefix, so keypad dot is ignored.
*/
module key_decoder (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic [7:0] scan_code,
  input  logic       code_strobe,
  output logic       reset_key,
  output logic       master_reset,
  output logic       video_mode
);

  logic brk_pend;    // F0 seen
  logic ext_pend;    // E0 seen
  logic make;
  logic is_prefix;
  logic ctrl_held;
  logic alt_held;
  logic del_held;
  logic bksp_held;

  assign make      = !brk_pend;
  assign is_prefix = (scan_code == kbd_pkg::code_break) || (scan_code == kbd_pkg::code_ext);

  // Prefix and key state ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      brk_pend   <= 1'b0;
      ext_pend   <= 1'b0;
      ctrl_held  <= 1'b0;
      alt_held   <= 1'b0;
      del_held   <= 1'b0;
      bksp_held  <= 1'b0;
      video_mode <= 1'b0;
    end else if (code_strobe) begin
      if (is_prefix) begin
        if (scan_code == kbd_pkg::code_break) begin
          brk_pend <= 1'b1;
        end else begin
          ext_pend <= 1'b1;
        end
      end else begin
        brk_pend <= 1'b0;   // Prefixes apply to one code only
        ext_pend <= 1'b0;
        case (scan_code)
          kbd_pkg::code_ctrl: ctrl_held <= make;
          kbd_pkg::code_alt:  alt_held  <= make;
          kbd_pkg::code_bksp: bksp_held <= make;
          kbd_pkg::code_del: begin
            if (ext_pend) begin
              del_held <= make;
            end
          end
          kbd_pkg::code_scroll: begin
            if (make) begin
              video_mode <= !video_mode;   // Release leaves mode alone
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Combination levels follow the held keys directly
  assign reset_key    = ctrl_held && alt_held && del_held;
  assign master_reset = ctrl_held && alt_held && bksp_held;

endmodule

// ==== source/reset_ctrl.sv ====
/*
  Core reset and reboot request generation.
  core_reset_n rises 257 cycles after pll_lckd goes high if nothing holds it.
  reboot_req is one cycle wide and stays quiet during the power-on delay.
*/
module reset_ctrl (
  input  logic               ena_x,
  input  logic               pll_lckd,
  input  logic               reset_key,
  input  logic               master_reset,
  input  joy_pkg::joy_word_u joy1,
  input  joy_pkg::joy_word_u joy2,
  output logic               core_reset_n,
  output logic               reboot_req
);

  logic [7:0] por_cnt;
  logic       por_done;
  logic       reboot_cond;
  logic       reboot_cond_q;

  // Keyboard combo or the reset pin on controller two
  assign reboot_cond = master_reset || !joy2.fields.reset_n;

  // Power-on delay ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      por_cnt  <= '0;
      por_done <= 1'b0;
    end else if (!por_done) begin
      if (&por_cnt) begin
        por_done <= 1'b1;   // Counter holds at full scale
      end else begin
        por_cnt <= por_cnt + 1'b1;
      end
    end
  end

  // Outputs ------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      core_reset_n  <= 1'b0;
      reboot_cond_q <= 1'b0;
      reboot_req    <= 1'b0;
    end else begin
      core_reset_n  <= por_done && !reset_key && joy1.fields.reset_n;
      reboot_cond_q <= reboot_cond;
      reboot_req    <= por_done && reboot_cond && !reboot_cond_q;   // Rising edge only
    end
  end

endmodule

// ==== source/arcade_input_top.sv ====
/*
  Input and control front end of the arcade board.
  Everything runs on ena_x. pll_lckd low resets every block.
  Only reboot_req leaves for the multiboot logic, which sits outside.
*/
module arcade_input_top (
  input  logic               ena_x,
  input  logic               pll_lckd,
  input  logic               joy_data,
  input  logic               ps2_clk,
  input  logic               ps2_data,
  output logic               joy_clk,
  output logic               joy_load,
  output joy_pkg::joy_word_u joy1,
  output joy_pkg::joy_word_u joy2,
  output logic               core_reset_n,
  output logic               reboot_req,
  output logic               video_mode
);

  logic [7:0] scan_code;
  logic       code_strobe;
  logic       reset_key;
  logic       master_reset;

  // Joystick chain
  joy_serial_reader u_joy (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .joy_clk  (joy_clk),
    .joy_load (joy_load),
    .joy1     (joy1),
    .joy2     (joy2)
  );

  // Keyboard ------------------------------
  ps2_receiver u_rx (
    .ena_x       (ena_x),
    .pll_lckd    (pll_lckd),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .scan_code   (scan_code),
    .code_strobe (code_strobe),
    .frame_err   ()              // Bad frames are simply dropped
  );

  key_decoder u_dec (
    .ena_x        (ena_x),
    .pll_lckd     (pll_lckd),
    .scan_code    (scan_code),
    .code_strobe  (code_strobe),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .video_mode   (video_mode)
  );

  // Reset and reboot
  reset_ctrl u_rst (
    .ena_x        (ena_x),
    .pll_lckd     (pll_lckd),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .joy1         (joy1),
    .joy2         (joy2),
    .core_reset_n (core_reset_n),
    .reboot_req   (reboot_req)
  );

endmodule

// ==== tb/tb_arcade_input.sv ====
/*
  Testbench for the arcade input front end.
  Models the joystick shift chain and a PS/2 keyboard. Assertions do the checking.
  Inputs change on the falling ena_x edge.
*/
module tb_arcade_input;

  localparam int frame_cycles    = joy_pkg::joy_frame_slots * joy_pkg::joy_slot_cycles;
  localparam int por_cycles      = 257;
  localparam int ps2_half        = 10;   // 20 cycles per PS/2 bit
  localparam int ps2_gap         = 40;
  localparam int ps2_frame_len   = 22 * ps2_half + ps2_gap;
  localparam int watchdog_cycles = 20 * frame_cycles + 40 * ps2_frame_len + 400;

  logic               ena_x;
  logic               pll_lckd;
  logic               joy_data;
  logic               ps2_clk;
  logic               ps2_data;
  logic               joy_clk;
  logic               joy_load;
  joy_pkg::joy_word_u joy1;
  joy_pkg::joy_word_u joy2;
  logic               core_reset_n;
  logic               reboot_req;
  logic               video_mode;

  integer             seed = 32'hfa081274;
  int                 errors = 0;
  int                 test_errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 cyc;
  int                 low_len;
  int                 since_fall;
  int                 pulses = 0;
  int                 mark;
  logic               load_q;
  logic               load_prev;
  logic               jclk_prev;
  logic               p1_rst = 1'b1;   // Reset bits put into the next patterns
  logic               p2_rst = 1'b1;
  logic               kbd_hold = 1'b0;
  logic               combo_held = 1'b0;
  logic               exp_video = 1'b0;
  logic [23:0]        pattern;
  logic [25:0]        chain;
  joy_pkg::joy_word_u exp1_cur;
  joy_pkg::joy_word_u exp2_cur;
  joy_pkg::joy_word_u exp1_pub;
  joy_pkg::joy_word_u exp2_pub;

  arcade_input_top dut (.*);

  initial begin
    ena_x = 1'b0;
    forever #5 ena_x = ~ena_x;
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("Watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_errors) tests_failed++;
    $display("Test %0d %s done, %0d errors", tests_run, name, errors - test_errors);
    test_errors = errors;
  endtask

  // Joystick chain model ------------------------------
  function automatic logic [23:0] draw_pattern();
    logic [31:0] rnd;
    logic [23:0] pat;
    int          s;
    rnd = $random(seed);
    pat = rnd[23:0];
    for (s = 2; s < joy_pkg::joy_frame_slots; s++) begin
      if (joy_pkg::joy_slot_map[s] == {joy_pkg::joy_dst_p1, 4'd11}) pat[s-2] = p1_rst;
      if (joy_pkg::joy_slot_map[s] == {joy_pkg::joy_dst_p2, 4'd11}) pat[s-2] = p2_rst;
    end
    return pat;
  endfunction

  // Chain bit n reaches joy_data in slot n + 2
  task automatic expect_words(input logic [23:0] pat, output joy_pkg::joy_word_u w1,
                              output joy_pkg::joy_word_u w2);
    logic [5:0] entry;
    int         s;
    w1.raw = '1;
    w2.raw = '1;
    for (s = 2; s < joy_pkg::joy_frame_slots; s++) begin
      entry = joy_pkg::joy_slot_map[s];
      if (entry[5:4] == joy_pkg::joy_dst_p1) w1.raw[entry[3:0]] = pat[s-2];
      if (entry[5:4] == joy_pkg::joy_dst_p2) w2.raw[entry[3:0]] = pat[s-2];
    end
  endtask

  always @(negedge ena_x) begin
    if (!pll_lckd) begin
      exp1_cur.raw = '1;
      exp2_cur.raw = '1;
      exp1_pub.raw = '1;
      exp2_pub.raw = '1;
      chain        = '1;
      load_prev    = 1'b1;
      jclk_prev    = 1'b0;
    end else begin
      if (!joy_load) begin
        if (load_prev) begin   // New frame, last one gets published
          exp1_pub = exp1_cur;
          exp2_pub = exp2_cur;
          pattern  = draw_pattern();
          expect_words(pattern, exp1_cur, exp2_cur);
        end
        chain = {pattern, 2'b11};   // Two dummy stages ahead of the data
      end else if (joy_clk && !jclk_prev) begin
        chain = {1'b1, chain[25:1]};
      end
      load_prev = joy_load;
      jclk_prev = joy_clk;
    end
    joy_data = chain[0];
  end

  always @(negedge ena_x) begin
    if (pll_lckd && reboot_req) pulses++;
  end

  always @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      cyc        <= 0;
      low_len    <= 0;
      since_fall <= 0;
      load_q     <= 1'b1;
    end else begin
      cyc        <= cyc + 1;
      low_len    <= joy_load ? 0 : low_len + 1;
      since_fall <= (load_q && !joy_load) ? 1 : since_fall + 1;
      load_q     <= joy_load;
    end
  end

  // Assertions ------------------------------
  a_por_low: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (cyc < por_cycles) |-> !core_reset_n) else note_error("core_reset_n high too early");
  a_por_rise: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (cyc == por_cycles) |-> core_reset_n) else note_error("core_reset_n not high at 257");
  a_core_follow: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (cyc >= por_cycles && !kbd_hold) |-> (core_reset_n == $past(joy1.fields.reset_n)))
    else note_error("core_reset_n does not follow joy1 reset_n");
  a_combo_low: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    combo_held |-> !core_reset_n) else note_error("core_reset_n high during Ctrl+Alt+Del");
  a_reboot_por: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (cyc < por_cycles) |-> !reboot_req) else note_error("reboot_req during power-on delay");
  a_reboot_single: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    $past(reboot_req) |-> !reboot_req) else note_error("reboot_req wider than one cycle");
  a_load_len: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    $rose(joy_load) |-> (low_len == joy_pkg::joy_slot_cycles))
    else note_error("joy_load low pulse has wrong width");
  a_load_period: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    ($fell(joy_load) && cyc > 3) |-> (since_fall == frame_cycles))
    else note_error("joy_load period is not one frame");
  a_jclk_toggle: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (cyc > 2) |-> (joy_clk != $past(joy_clk)))
    else note_error("joy_clk does not toggle every cycle");
  a_jclk_phase: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    $fell(joy_load) |-> !joy_clk)
    else note_error("joy_clk high in the first cycle of a slot");
  a_joy_words: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !$fell(joy_load) |-> (joy1.raw == exp1_pub.raw && joy2.raw == exp2_pub.raw))
    else note_error("joy1 or joy2 differs from the loaded pattern");

  // PS/2 keyboard model ------------------------------
  task automatic send_byte(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    int          b;
    frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};   // Stop, odd parity, data, start
    for (b = 0; b < 11; b++) begin
      ps2_data = frame[b];
      repeat (ps2_half) @(negedge ena_x);
      ps2_clk = 1'b0;
      repeat (ps2_half) @(negedge ena_x);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (ps2_gap) @(negedge ena_x);
  endtask

  task automatic key_press(input logic [7:0] code, input logic ext);
    if (ext) send_byte(kbd_pkg::code_ext, 1'b0);
    send_byte(code, 1'b0);
  endtask

  task automatic key_lift(input logic [7:0] code, input logic ext);
    if (ext) send_byte(kbd_pkg::code_ext, 1'b0);
    send_byte(kbd_pkg::code_break, 1'b0);
    send_byte(code, 1'b0);
  endtask

  task automatic check_video();
    assert (video_mode == exp_video) else note_error("video_mode has the wrong value");
  endtask

  task automatic wait_frames(input int n);
    repeat (n) @(negedge joy_load);
    @(negedge ena_x);
  endtask

  // Test sequence ------------------------------
  initial begin
    pll_lckd = 1'b0;
    joy_data = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    p2_rst   = 1'b0;   // Controller two asks for a reboot inside the power-on delay
    repeat (2) @(posedge ena_x);
    @(negedge ena_x);
    assert (joy_load && !reboot_req && !core_reset_n && (&joy1.raw) && (&joy2.raw))
      else note_error("outputs not at their reset values");
    pll_lckd = 1'b1;
    while (cyc < 2 * frame_cycles) @(negedge ena_x);
    p2_rst = 1'b1;
    while (cyc < por_cycles + 5) @(negedge ena_x);
    end_test("power-on reset");

    wait_frames(4);
    end_test("joystick frames");

    key_press(kbd_pkg::code_scroll, 1'b0);
    exp_video = ~exp_video;
    check_video();
    key_lift(kbd_pkg::code_scroll, 1'b0);
    check_video();
    key_press(kbd_pkg::code_scroll, 1'b0);
    exp_video = ~exp_video;
    check_video();
    send_byte(kbd_pkg::code_scroll, 1'b1);   // Bad parity, must be dropped
    check_video();
    end_test("video mode toggle");

    kbd_hold = 1'b1;
    key_press(kbd_pkg::code_ctrl, 1'b0);
    key_press(kbd_pkg::code_alt, 1'b0);
    key_press(kbd_pkg::code_del, 1'b1);
    combo_held = 1'b1;
    repeat (100) @(negedge ena_x);
    combo_held = 1'b0;
    key_lift(kbd_pkg::code_del, 1'b1);
    assert (core_reset_n) else note_error("core_reset_n still low after Del release");
    key_lift(kbd_pkg::code_ctrl, 1'b0);
    key_lift(kbd_pkg::code_alt, 1'b0);
    kbd_hold = 1'b0;
    end_test("Ctrl+Alt+Del core reset");

    mark = pulses;
    key_press(kbd_pkg::code_ctrl, 1'b0);
    key_press(kbd_pkg::code_alt, 1'b0);
    key_press(kbd_pkg::code_bksp, 1'b0);
    assert (pulses == mark + 1) else note_error("wrong reboot_req count after Backspace");
    key_lift(kbd_pkg::code_bksp, 1'b0);
    key_lift(kbd_pkg::code_ctrl, 1'b0);
    key_lift(kbd_pkg::code_alt, 1'b0);
    p2_rst = 1'b0;
    wait_frames(3);
    p2_rst = 1'b1;
    wait_frames(3);
    assert (pulses == mark + 2) else note_error("wrong reboot_req count after joy2 reset");
    end_test("reboot request");

    p1_rst = 1'b0;
    wait_frames(3);
    assert (!core_reset_n) else note_error("core_reset_n high while joy1 reset_n is low");
    p1_rst = 1'b1;
    wait_frames(3);
    assert (core_reset_n) else note_error("core_reset_n low after joy1 reset_n restored");
    end_test("joystick core reset");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
source/joy_pkg.sv
source/kbd_pkg.sv
source/joy_serial_reader.sv
source/ps2_receiver.sv
source/key_decoder.sv
source/reset_ctrl.sv
source/arcade_input_top.sv
tb/tb_arcade_input.sv
